// File: clk_cluster_top.f
+incdir+include
hdl/cluster_pkg.sv
hdl/seq_pkg.sv
hdl/cluster_link_if.sv
hdl/cluster_enable_ctrl.sv
hdl/cluster_header.sv
hdl/cluster_status_collector.sv
hdl/clk_cluster_top.sv
verification/clk_cluster_assert.sv
verification/clk_cluster_tb.sv

// File: Makefile
SIM = obj_dir/Vclk_cluster_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f clk_cluster_top.f \
		--top-module clk_cluster_tb -o Vclk_cluster_tb

run: compile
	./$(SIM) | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

// File: verification/clk_cluster_tb.sv
// Testbench for clk_cluster_top; checking lives in the bound assertions plus rclk edge counts
`timescale 1ns/1ps
`include "clk_cluster_config.svh"

module clk_cluster_tb;

   logic                        gclk;
   logic                        rst_n;
   logic                        req;
   cluster_pkg::cluster_mask_t  cmd_mask;
   logic                        grst_in;
   logic                        dbginit_in;
   logic                        ack;
   cluster_pkg::cluster_mask_t  rclk;
   cluster_pkg::cluster_mask_t  cluster_grst_l;
   cluster_pkg::cluster_mask_t  cluster_dbginit_l;
   cluster_pkg::cluster_mask_t  running;

   int    mismatch_count;
   int    timeout_count;
   logic  requests_done;
   logic  clear_counts;
   // rclk rising edges per cluster since the last clear
   int    edge_count [`CLUSTER_COUNT];

   clk_cluster_top dut (
      .gclk              (gclk),
      .rst_n             (rst_n),
      .req               (req),
      .cmd_mask          (cmd_mask),
      .grst_in           (grst_in),
      .dbginit_in        (dbginit_in),
      .ack               (ack),
      .rclk              (rclk),
      .cluster_grst_l    (cluster_grst_l),
      .cluster_dbginit_l (cluster_dbginit_l),
      .running           (running)
   );

   initial begin
      gclk = 1'b0;
      forever #4 gclk = ~gclk;
   end

   // One edge counter per gated clock
   for (genvar i = 0; i < `CLUSTER_COUNT; i++) begin : g_count
      int count;

      always @(posedge rclk[i] or posedge clear_counts) begin
         if (clear_counts) begin
            count = 0;
         end else begin
            count = count + 1;
         end
      end

      assign edge_count[i] = count;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // 40 requests with an all-zero mask first, an all-one mask next and random masks after
   task automatic run_requests();
      logic [31:0]                 seed;
      cluster_pkg::cluster_mask_t  mask;
      int                          hold;
      int                          waited;
      int                          expected;
      seed = 32'h5756;
      for (int n = 0; n < 40; n++) begin
         seed = lcg_next(seed);
         if (n == 0) begin
            mask = '0;
         end else if (n == 1) begin
            mask = '1;
         end else begin
            mask = seed[`CLUSTER_COUNT+15:16];
         end
         cmd_mask = mask;
         req      = 1'b1;
         waited   = 0;
         while (!ack && waited < `ACK_TIMEOUT) begin
            @(posedge gclk);
            #1;
            waited++;
         end
         if (!ack) begin
            $display("Handshake timeout: no ack for request %0d", n);
            timeout_count++;
            req = 1'b0;
            break;
         end
         // Back-pressure length in cycles after ack
         seed = lcg_next(seed);
         hold = int'(seed[18:16]);
         clear_counts = 1'b1;
         #1 clear_counts = 1'b0;
         for (int c = 0; c < 16; c++) begin
            @(posedge gclk);
            #1;
            if (c == hold) begin
               req = 1'b0;
            end else if (c < hold) begin
               // Ignored while ack is up
               seed     = lcg_next(seed);
               cmd_mask = seed[`CLUSTER_COUNT+15:16];
            end
         end
         for (int i = 0; i < `CLUSTER_COUNT; i++) begin
            expected = mask[i] ? 16 : 0;
            if (edge_count[i] != expected) begin
               $display("CHECK FAILED clock_gating req=%0d cluster=%0d expected=%0d actual=%0d",
                        n, i, expected, edge_count[i]);
               mismatch_count++;
            end
         end
         waited = 0;
         while (ack && waited < `ACK_TIMEOUT) begin
            @(posedge gclk);
            #1;
            waited++;
         end
         if (ack) begin
            $display("Handshake timeout: ack stuck high after request %0d", n);
            timeout_count++;
            break;
         end
      end
      requests_done = 1'b1;
   endtask

   // Random reset and debug-init toggles that hold each level 4 to 7 cycles
   task automatic toggle_repeaters();
      logic [31:0] seed;
      seed = lcg_next(32'h5756);
      while (!requests_done) begin
         seed = lcg_next(seed);
         case (seed[25:24])
            2'd0: grst_in = ~grst_in;
            2'd1: dbginit_in = ~dbginit_in;
            2'd2: begin
               grst_in    = ~grst_in;
               dbginit_in = ~dbginit_in;
            end
            default: ;
         endcase
         repeat (4 + int'(seed[29:28])) @(posedge gclk);
         #1;
      end
   endtask

   // Watchdog sized from the request count
   initial begin
      repeat (40 * (`ACK_TIMEOUT + 20)) @(posedge gclk);
      $display("Watchdog expired: run did not finish within %0d cycles",
               40 * (`ACK_TIMEOUT + 20));
      $display("TB FAILED");
      $finish;
   end

   initial begin
      rst_n          = 1'b0;
      req            = 1'b0;
      cmd_mask       = '0;
      grst_in        = 1'b1;
      dbginit_in     = 1'b1;
      clear_counts   = 1'b0;
      requests_done  = 1'b0;
      mismatch_count = 0;
      timeout_count  = 0;
      repeat (2) @(posedge gclk);
      #1 rst_n = 1'b1;
      // Reset exit window watched by the assertions
      repeat (3) @(posedge gclk);
      #1;
      fork
         run_requests();
         toggle_repeaters();
      join
      $display("Errors: assertions=%0d clock_gating=%0d handshake_timeouts=%0d",
               dut.u_assert.fail_count, mismatch_count, timeout_count);
      if (dut.u_assert.fail_count == 0 && mismatch_count == 0 && timeout_count == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// File: verification/clk_cluster_assert.sv
// Protocol and repeater checks for clk_cluster_top; inputs must hold each level 3+ cycles
`timescale 1ns/1ps
`include "clk_cluster_config.svh"

module clk_cluster_assert (
   input  logic                        gclk,
   input  logic                        rst_n,
   input  logic                        req,
   input  cluster_pkg::cluster_mask_t  cmd_mask,
   input  logic                        grst_in,
   input  logic                        dbginit_in,
   input  logic                        ack,
   input  cluster_pkg::cluster_mask_t  rclk,
   input  cluster_pkg::cluster_mask_t  cluster_grst_l,
   input  cluster_pkg::cluster_mask_t  cluster_dbginit_l,
   input  cluster_pkg::cluster_mask_t  running,
   input  seq_pkg::seq_state_t         state
);

   // Mask of the request that is currently open
   cluster_pkg::cluster_mask_t  req_mask_q;
   // Request accepted by the sequencer at this edge
   logic                        req_taken;
   // ack, running and both repeater outputs at their reset level
   logic                        outputs_quiet;
   // Assertion failures so far
   int                          fail_count = 0;

   assign req_taken     = (state == seq_pkg::IDLE) && req && !ack;
   assign outputs_quiet = !ack && running == '0
                          && cluster_grst_l == '0 && cluster_dbginit_l == '0;

   always_ff @(posedge gclk or negedge rst_n) begin
      if (!rst_n) begin
         req_mask_q <= '0;
      end else if (req_taken) begin
         req_mask_q <= cmd_mask;
      end
   end

   // Everything quiet while in reset
   a_reset_quiet: assert property (@(posedge gclk)
      !rst_n |-> outputs_quiet)
      else begin
         $error("outputs active during reset");
         fail_count++;
      end

   // Still quiet for two edges after release
   a_reset_exit: assert property (@(posedge gclk)
      $rose(rst_n) |-> outputs_quiet ##1 outputs_quiet)
      else begin
         $error("ack, clocks or repeaters active right after reset");
         fail_count++;
      end

   // Sampled at the falling edge, rclk shows the high phase just gone
   a_reset_rclk: assert property (@(negedge gclk)
      (!rst_n || $rose(rst_n)) |-> (rclk == '0) ##1 (rclk == '0))
      else begin
         $error("rclk toggled during or right after reset");
         fail_count++;
      end

   // ack high exactly four edges after the request was taken
   a_ack_latency: assert property (@(posedge gclk) disable iff (!rst_n)
      req_taken |-> !ack ##1 !ack ##1 !ack ##1 !ack ##1 !ack ##1 ack)
      else begin
         $error("ack latency differs from four cycles");
         fail_count++;
      end

   // ack drops one edge after req seen low
   a_ack_fall: assert property (@(posedge gclk) disable iff (!rst_n)
      (state == seq_pkg::WAIT_REQ_LOW && ack && !req) |=> ack ##1 !ack)
      else begin
         $error("ack did not fall one edge after req low");
         fail_count++;
      end

   a_ack_needs_req: assert property (@(posedge gclk) disable iff (!rst_n)
      $rose(ack) |-> req)
      else begin
         $error("ack rose while req was low");
         fail_count++;
      end

   // Clusters hold the requested mask for the whole ack phase
   a_running_held: assert property (@(posedge gclk) disable iff (!rst_n)
      ack |-> (running == req_mask_q))
      else begin
         $error("running differs from the acknowledged mask");
         fail_count++;
      end

   // Repeaters assert at once and release after SYNC_STAGES edges
   a_grst_low: assert property (@(posedge gclk) disable iff (!rst_n)
      !grst_in |-> (cluster_grst_l == '0))
      else begin
         $error("cluster reset not low while grst_in low");
         fail_count++;
      end

   a_grst_release: assert property (@(posedge gclk) disable iff (!rst_n)
      $rose(grst_in) |-> ##(`SYNC_STAGES-1) (cluster_grst_l == '0) ##1 (&cluster_grst_l))
      else begin
         $error("cluster reset release timing wrong");
         fail_count++;
      end

   a_dbginit_low: assert property (@(posedge gclk) disable iff (!rst_n)
      !dbginit_in |-> (cluster_dbginit_l == '0))
      else begin
         $error("cluster debug-init not low while dbginit_in low");
         fail_count++;
      end

   a_dbginit_release: assert property (@(posedge gclk) disable iff (!rst_n)
      $rose(dbginit_in) |-> ##(`SYNC_STAGES-1) (cluster_dbginit_l == '0)
                             ##1 (&cluster_dbginit_l))
      else begin
         $error("cluster debug-init release timing wrong");
         fail_count++;
      end

endmodule

bind clk_cluster_top clk_cluster_assert u_assert (
   .gclk              (gclk),
   .rst_n             (rst_n),
   .req               (req),
   .cmd_mask          (cmd_mask),
   .grst_in           (grst_in),
   .dbginit_in        (dbginit_in),
   .ack               (ack),
   .rclk              (rclk),
   .cluster_grst_l    (cluster_grst_l),
   .cluster_dbginit_l (cluster_dbginit_l),
   .running           (running),
   .state             (u_enable_ctrl.state_q)
);

// File: hdl/clk_cluster_top.sv
// Cluster clock block top; all inputs sync to gclk except the repeater inputs
`timescale 1ns/1ps
`include "clk_cluster_config.svh"

module clk_cluster_top (
   input  logic                        gclk,
   input  logic                        rst_n,
   input  logic                        req,
   input  cluster_pkg::cluster_mask_t  cmd_mask,
   input  logic                        grst_in,
   input  logic                        dbginit_in,
   output logic                        ack,
   output cluster_pkg::cluster_mask_t  rclk,
   output cluster_pkg::cluster_mask_t  cluster_grst_l,
   output cluster_pkg::cluster_mask_t  cluster_dbginit_l,
   output cluster_pkg::cluster_mask_t  running
);

   // One link per cluster
   cluster_link_if link [`CLUSTER_COUNT] ();

   // Collector to sequencer
   logic settled;

   cluster_enable_ctrl u_enable_ctrl (
      .gclk     (gclk),
      .rst_n    (rst_n),
      .req      (req),
      .cmd_mask (cmd_mask),
      .settled  (settled),
      .ack      (ack),
      .links    (link)
   );

   // Header per cluster, outputs flattened onto the plain ports
   for (genvar i = 0; i < `CLUSTER_COUNT; i++) begin : g_cluster
      cluster_header u_header (
         .gclk       (gclk),
         .rst_n      (rst_n),
         .grst_in    (grst_in),
         .dbginit_in (dbginit_in),
         .rclk       (rclk[i]),
         .link       (link[i])
      );

      assign running[i]           = link[i].run;
      assign cluster_grst_l[i]    = link[i].grst_l;
      assign cluster_dbginit_l[i] = link[i].dbginit_l;
   end

   cluster_status_collector u_status_collector (
      .gclk    (gclk),
      .rst_n   (rst_n),
      .settled (settled),
      .links   (link)
   );

endmodule

// File: hdl/cluster_status_collector.sv
// Settle detector; settled lags the headers by one gclk edge
`timescale 1ns/1ps
`include "clk_cluster_config.svh"

module cluster_status_collector (
   input  logic          gclk,
   input  logic          rst_n,
   output logic          settled,
   cluster_link_if.mon   links [`CLUSTER_COUNT]
);

   cluster_pkg::cluster_mask_t  cken_vec;
   cluster_pkg::cluster_mask_t  run_vec;
   // cken seen at the previous edge, for change detection
   cluster_pkg::cluster_mask_t  cken_prev_q;
   logic                        all_match;
   logic                        cken_changed;

   // Gather the per-link bits into masks
   for (genvar i = 0; i < `CLUSTER_COUNT; i++) begin : g_gather
      assign cken_vec[i] = links[i].cken;
      assign run_vec[i]  = links[i].run;
   end

   assign all_match    = (run_vec == cken_vec);
   // A fresh cken edge means run has not caught up yet
   assign cken_changed = (cken_vec != cken_prev_q);

   always_ff @(posedge gclk or negedge rst_n) begin
      if (!rst_n) begin
         cken_prev_q <= '0;
         settled     <= 1'b0;
      end else begin
         cken_prev_q <= cken_vec;
         settled     <= all_match && !cken_changed;
      end
   end

endmodule

// File: hdl/cluster_header.sv
// Cluster clock gate and reset repeaters; gclk must be free running, rclk is gclk AND run
`timescale 1ns/1ps
`include "clk_cluster_config.svh"

module cluster_header (
   input  logic         gclk,
   input  logic         rst_n,
   input  logic         grst_in,
   input  logic         dbginit_in,
   output logic         rclk,
   cluster_link_if.hdr  link
);

   // Repeater count: index 0 is reset, index 1 is debug-init
   localparam int REP_COUNT = 2;

   // Enable synchronizer, master flop on rising edge
   logic                  cken_rise_q;
   // Lock-up stage on falling edge, only changes while gclk is low
   logic                  run_q;
   // Repeater inputs and outputs
   logic [REP_COUNT-1:0]  rep_in;
   logic [REP_COUNT-1:0]  rep_out;

   always_ff @(posedge gclk or negedge rst_n) begin
      if (!rst_n) begin
         cken_rise_q <= 1'b0;
      end else begin
         cken_rise_q <= link.cken;
      end
   end

   always_ff @(negedge gclk or negedge rst_n) begin
      if (!rst_n) begin
         run_q <= 1'b0;
      end else begin
         run_q <= cken_rise_q;
      end
   end

   // Gate opens or closes during the low phase, so no runt pulses
   assign rclk     = gclk & run_q;
   assign link.run = run_q;

   assign rep_in = {dbginit_in, grst_in};

   // Assert asynchronously, release after SYNC_STAGES rising edges
   for (genvar r = 0; r < REP_COUNT; r++) begin : g_rep
      logic [`SYNC_STAGES-1:0] stage_q;
      logic                    clr_n;

      // Global reset or a low input clears the whole chain at once
      assign clr_n = rst_n & rep_in[r];

      always_ff @(posedge gclk or negedge clr_n) begin
         if (!clr_n) begin
            stage_q <= '0;
         end else begin
            // Shift in ones toward the output
            stage_q <= {stage_q[`SYNC_STAGES-2:0], 1'b1};
         end
      end

      assign rep_out[r] = stage_q[`SYNC_STAGES-1];
   end

   assign link.grst_l    = rep_out[0];
   assign link.dbginit_l = rep_out[1];

endmodule

// File: hdl/cluster_enable_ctrl.sv
// Four-phase req/ack sequencer; requester must hold cmd_mask while req is high
`timescale 1ns/1ps
`include "clk_cluster_config.svh"

module cluster_enable_ctrl (
   input  logic                        gclk,
   input  logic                        rst_n,
   input  logic                        req,
   input  cluster_pkg::cluster_mask_t  cmd_mask,
   input  logic                        settled,
   output logic                        ack,
   cluster_link_if.ctrl                links [`CLUSTER_COUNT]
);

   seq_pkg::seq_state_t         state_q;
   // Mask currently applied to the clusters
   cluster_pkg::cluster_mask_t  applied_q;
   // Skips the first WAIT_SETTLE cycle, where settled may still be stale
   logic                        settle_wait_q;

   // Every cluster enable comes straight from the applied mask
   for (genvar i = 0; i < `CLUSTER_COUNT; i++) begin : g_cken
      assign links[i].cken = applied_q[i];
   end

   always_ff @(posedge gclk or negedge rst_n) begin
      if (!rst_n) begin
         state_q       <= seq_pkg::IDLE;
         applied_q     <= '0;
         settle_wait_q <= 1'b0;
         ack           <= 1'b0;
      end else begin
         // ack trails the state by one edge
         // Rises one edge after settle, falls one edge after req low
         ack <= (state_q == seq_pkg::WAIT_REQ_LOW);

         case (state_q)
            seq_pkg::IDLE: begin
               // New request only once the previous ack is gone
               if (req && !ack) begin
                  applied_q <= cmd_mask;
                  state_q   <= seq_pkg::APPLY;
               end
            end

            seq_pkg::APPLY: begin
               // Header and collector need a fixed number of edges to follow
               settle_wait_q <= 1'b1;
               state_q       <= seq_pkg::WAIT_SETTLE;
            end

            seq_pkg::WAIT_SETTLE: begin
               // Same delay whether or not the mask changed
               if (settle_wait_q) begin
                  settle_wait_q <= 1'b0;
               end else if (settled) begin
                  state_q <= seq_pkg::WAIT_REQ_LOW;
               end
            end

            seq_pkg::WAIT_REQ_LOW: begin
               // cmd_mask ignored here, applied_q stays put
               if (!req) begin
                  state_q <= seq_pkg::IDLE;
               end
            end

            default: begin
               state_q <= seq_pkg::IDLE;
            end
         endcase
      end
   end

endmodule

// File: hdl/cluster_link_if.sv
// One cluster link; all signals single bit, in the gclk domain
`timescale 1ns/1ps

interface cluster_link_if;

   // Requested clock enable from the sequencer
   logic cken;
   // Enable after the header synchronizer, the one gating rclk
   logic run;
   // Cluster reset, active low, released on gclk
   logic grst_l;
   // Cluster debug-init, active low, released on gclk
   logic dbginit_l;

   // Sequencer side
   modport ctrl (
      output cken
   );

   // Cluster header side
   modport hdr (
      input  cken,
      output run,
      output grst_l,
      output dbginit_l
   );

   // Observers: status collector and top-level flattening
   modport mon (
      input cken,
      input run,
      input grst_l,
      input dbginit_l
   );

endinterface

// File: hdl/seq_pkg.sv
// Enable sequencer types; encoding is internal and may change freely
package seq_pkg;

   // States of the req/ack enable sequencer
   typedef enum logic [1:0] {
      // Waiting for a new mask request
      IDLE,
      // New mask has just been driven onto cken
      APPLY,
      // Waiting for the collector to report all clusters settled
      WAIT_SETTLE,
      // ack is up, holding until the requester drops req
      WAIT_REQ_LOW
   } seq_state_t;

endpackage

// File: hdl/cluster_pkg.sv
// Cluster-level types; widths follow CLUSTER_COUNT from the config header
`include "clk_cluster_config.svh"

package cluster_pkg;

   // One bit per cluster
   // 1 = clock to run, 0 = clock gated off
   typedef logic [`CLUSTER_COUNT-1:0] cluster_mask_t;

   // Cluster index, just wide enough to number every cluster
   // Kept at least one bit wide for a single-cluster build
   typedef logic [(`CLUSTER_COUNT > 1 ? $clog2(`CLUSTER_COUNT) : 1)-1:0] cluster_id_t;

endpackage

// File: include/clk_cluster_config.svh
// Global sizing for the cluster clock block; SYNC_STAGES must be 2 or more
`ifndef CLK_CLUSTER_CONFIG_SVH
`define CLK_CLUSTER_CONFIG_SVH

// Number of processor clusters, each with its own header
`define CLUSTER_COUNT 4

// Flops per reset or debug-init repeater
// Release latency in gclk rising edges
`define SYNC_STAGES 2

// Cycles within which a req/ack handshake has to finish
`define ACK_TIMEOUT 8

`endif
